//--- build.f
+incdir+rtl
rtl/rv_pkg.sv
rtl/decode_if.sv
rtl/alu_decoder.sv
rtl/instr_decode.sv
rtl/reg_file.sv
rtl/alu.sv
rtl/rv_core.sv
sim/tb_rv_core.sv

//--- sim/tb_rv_core.sv
`timescale 1ns/1ps
`include "rv_config.svh"

module tb_rv_core import rv_pkg::*; ();

  localparam word_t SENTINEL    = 32'h0000_03FC;  // a store here ends each program
  localparam word_t RESULT_BASE = 32'h0000_0100;
  localparam word_t NOP         = 32'h0000_0013;
  localparam int    MAX_CYCLES  = 400;

  logic  clk;
  logic  rst_n;
  word_t imem_addr;
  word_t imem_rdata;
  word_t dmem_addr;
  word_t dmem_wdata;
  logic  dmem_we;
  word_t dmem_rdata;

  word_t imem [256];
  word_t dmem [256];
  word_t prog [$];
  word_t exp_addr [$];
  word_t exp_data [$];
  word_t st_addr [$];   // store log from the data memory model
  word_t st_data [$];
  word_t pc_log [$];    // pc of each executed instruction
  word_t res_ptr;
  logic  sentinel_seen;
  word_t lcg_state = 32'd32147;

  rv_core DUT (
    .clk        (clk),
    .rst_n      (rst_n),
    .imem_addr  (imem_addr),
    .imem_rdata (imem_rdata),
    .dmem_addr  (dmem_addr),
    .dmem_wdata (dmem_wdata),
    .dmem_we    (dmem_we),
    .dmem_rdata (dmem_rdata)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  // both memories answer in the same cycle
  assign imem_rdata = imem[imem_addr[9:2]];
  assign dmem_rdata = dmem[dmem_addr[9:2]];

  always @(posedge clk) begin
    if (dmem_we) begin
      dmem[dmem_addr[9:2]] = dmem_wdata;
      st_addr.push_back(dmem_addr);
      st_data.push_back(dmem_wdata);
      if (dmem_addr == SENTINEL) sentinel_seen = 1'b1;
    end
  end

  function automatic word_t lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // instruction encoders
  function automatic word_t enc_r(logic [6:0] f7, reg_idx_t rs2, reg_idx_t rs1,
                                  logic [2:0] f3, reg_idx_t rd);
    return {f7, rs2, rs1, f3, rd, RType};
  endfunction
  function automatic word_t enc_i(logic [11:0] imm, reg_idx_t rs1, logic [2:0] f3,
                                  reg_idx_t rd, opcode_t op);
    return {imm, rs1, f3, rd, op};
  endfunction
  function automatic word_t enc_s(logic [11:0] imm, reg_idx_t rs2, reg_idx_t rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], SType};
  endfunction
  function automatic word_t enc_b(logic [12:0] imm, reg_idx_t rs2, reg_idx_t rs1,
                                  logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], BType};
  endfunction
  function automatic word_t enc_u(logic [19:0] imm, reg_idx_t rd, opcode_t op);
    return {imm, rd, op};
  endfunction
  function automatic word_t enc_j(logic [20:0] imm, reg_idx_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, JType};
  endfunction

  // RV32I results; alt selects sub or sra
  function automatic word_t ref_alu(logic [2:0] f3, logic alt, word_t a, word_t b);
    word_t r;
    case (f3)
      3'b000: r = alt ? a - b : a + b;
      3'b001: r = a << b[4:0];
      3'b010: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b011: r = (a < b) ? 32'd1 : 32'd0;
      3'b100: r = a ^ b;
      3'b101: begin
        if (alt) r = $signed(a) >>> b[4:0];
        else r = a >> b[4:0];
      end
      3'b110: r = a | b;
      default: r = a & b;
    endcase
    return r;
  endfunction

  function automatic logic branch_outcome(logic [2:0] f3, word_t a, word_t b);
    case (f3)
      3'b000: return a == b;
      3'b001: return a != b;
      3'b100: return $signed(a) < $signed(b);
      3'b101: return $signed(a) >= $signed(b);
      3'b110: return a < b;
      default: return a >= b;
    endcase
  endfunction

  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  task automatic stop_on_error();
    $display("*** FAILED ***");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (act !== exp) begin
      $display("Mismatch at %0t: %s expected %h, got %h", $time, name, exp, act);
      stop_on_error();
    end
  endtask

  task automatic check_pc(input word_t exp, input word_t act);
    if (act !== exp) begin
      $display("Mismatch at %0t: imem_addr expected %h, got %h", $time, exp, act);
      stop_on_error();
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Mismatch at %0t: %s expected %b, got %b", $time, name, exp, act);
      stop_on_error();
    end
  endtask

  task automatic new_program();
    prog.delete();
    exp_addr.delete();
    exp_data.delete();
    res_ptr = RESULT_BASE;
  endtask

  task automatic emit(input word_t instr);
    prog.push_back(instr);
  endtask

  function automatic word_t here();
    return prog.size() * 4;
  endfunction

  // lui + addi, upper part rounded for the sign of the low 12 bits
  task automatic load_const(input reg_idx_t rd, input word_t value);
    word_t upper;
    upper = (value + 32'h800) >> 12;
    emit(enc_u(upper[19:0], rd, UType_lui));
    emit(enc_i(value[11:0], rd, 3'b000, rd, IType_logic));
  endtask

  task automatic store_word(input reg_idx_t rs, input reg_idx_t base, input logic [11:0] off,
                            input word_t addr, input word_t data);
    emit(enc_s(off, rs, base));
    exp_addr.push_back(addr);
    exp_data.push_back(data);
  endtask

  task automatic store_result(input reg_idx_t rs, input word_t data);
    store_word(rs, 5'd0, res_ptr[11:0], res_ptr, data);
    res_ptr += 4;
  endtask

  task automatic apply_reset();
    rst_n = 1'b0;
    repeat (3) begin
      tick();
      check_pc(`RV_RESET_PC, imem_addr);
      check_bit("dmem_we", 1'b0, dmem_we);
    end
    st_addr.delete();
    st_data.delete();
    sentinel_seen = 1'b0;
    rst_n = 1'b1;
  endtask

  task automatic run_program();
    int cyc;
    store_word(5'd0, 5'd0, SENTINEL[11:0], SENTINEL, '0);
    for (int i = 0; i < 256; i++) begin
      imem[i] = (i < prog.size()) ? prog[i] : NOP;
      dmem[i] = 32'hA5C3_0000 ^ (i << 2);
    end
    apply_reset();
    pc_log.delete();
    cyc = 0;
    while (!sentinel_seen && cyc < MAX_CYCLES) begin
      pc_log.push_back(imem_addr);
      tick();
      cyc++;
    end
    if (!sentinel_seen) begin
      $display("Timeout: no store to %h within %0d cycles", SENTINEL, MAX_CYCLES);
      stop_on_error();
    end
    if (st_addr.size() != exp_addr.size()) begin
      $display("Wrong number of stores: expected %0d, got %0d", exp_addr.size(), st_addr.size());
      stop_on_error();
    end
    for (int i = 0; i < exp_addr.size(); i++) begin
      check_word($sformatf("store %0d dmem_addr", i), exp_addr[i], st_addr[i]);
      check_word($sformatf("store %0d dmem_wdata", i), exp_data[i], st_data[i]);
    end
  endtask

  task automatic test_reset_pc();
    new_program();
    store_result(5'd0, '0);   // a store at the reset pc, must stay quiet during reset
    run_program();
    check_pc(`RV_RESET_PC, pc_log[0]);
    check_pc(`RV_RESET_PC + 4, pc_log[1]);
  endtask

  task automatic test_alu_reg_imm();
    word_t a;
    word_t b;
    word_t r;
    word_t imm_x;
    logic [11:0] imm;
    logic [4:0] sh;
    logic [2:0] f3;
    logic alt;
    new_program();
    for (int s = 0; s < 2; s++) begin
      a = lcg_next();
      b = lcg_next();
      r = lcg_next();
      imm = r[23:12];
      sh = r[4:0];
      if (s == 0) begin
        imm[11] = 1'b1;   // negative immediate
      end else begin
        a[31] = 1'b1;     // sign fill for sra and srai
        b[31] = 1'b0;     // slt and sltu disagree
        imm[11] = 1'b0;   // slti and sltiu disagree
        imm[10] = 1'b1;   // addi whose imm looks like funct7 bit 5
      end
      imm_x = {{20{imm[11]}}, imm};
      load_const(5'd1, a);
      load_const(5'd2, b);
      for (int k = 0; k < 10; k++) begin
        f3 = (k < 8) ? k[2:0] : ((k == 8) ? 3'b000 : 3'b101);
        alt = (k >= 8);
        emit(enc_r(alt ? 7'b0100000 : 7'b0000000, 5'd2, 5'd1, f3, 5'd3));
        store_result(5'd3, ref_alu(f3, alt, a, b));
      end
      for (int k = 0; k < 8; k++) begin
        if (k != 1 && k != 5) begin
          emit(enc_i(imm, 5'd1, k[2:0], 5'd4, IType_logic));
          store_result(5'd4, ref_alu(k[2:0], 1'b0, a, imm_x));
        end
      end
      emit(enc_i({7'b0000000, sh}, 5'd1, 3'b001, 5'd4, IType_logic));
      store_result(5'd4, ref_alu(3'b001, 1'b0, a, {27'b0, sh}));
      emit(enc_i({7'b0000000, sh}, 5'd1, 3'b101, 5'd4, IType_logic));
      store_result(5'd4, ref_alu(3'b101, 1'b0, a, {27'b0, sh}));
      emit(enc_i({7'b0100000, sh}, 5'd1, 3'b101, 5'd4, IType_logic));
      store_result(5'd4, ref_alu(3'b101, 1'b1, a, {27'b0, sh}));
    end
    run_program();
  endtask

  task automatic test_load_store();
    word_t v [4];
    logic [11:0] offs [4] = '{12'h000, 12'h004, 12'hFFC, 12'h00C};
    new_program();
    emit(enc_i(12'h080, 5'd0, 3'b000, 5'd10, IType_logic));   // base pointer in x10
    for (int i = 0; i < 4; i++) begin
      v[i] = lcg_next();
      load_const(5'(i + 1), v[i]);
    end
    for (int i = 0; i < 4; i++) begin
      store_word(5'(i + 1), 5'd10, offs[i], 32'h80 + {{20{offs[i][11]}}, offs[i]}, v[i]);
    end
    for (int i = 0; i < 4; i++) emit(enc_i(offs[i], 5'd10, 3'b010, 5'(i + 11), IType_load));
    for (int i = 0; i < 4; i++) store_result(5'(i + 11), v[i]);
    emit(enc_i(12'h000, 5'd10, 3'b010, 5'd0, IType_load));   // load into x0 is dropped
    store_result(5'd0, '0);
    run_program();
  endtask

  task automatic test_branches();
    logic [2:0] f3_list [6] = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
    word_t a;
    word_t b;
    logic taken;
    new_program();
    for (int i = 0; i < 6; i++) begin
      for (int c = 0; c < 2; c++) begin
        a = lcg_next();
        b = a;
        if (c == 1) begin
          b = lcg_next();
          a[31] = ~f3_list[i][1];   // negative against positive, swapped for bltu and bgeu
          b[31] = f3_list[i][1];
        end
        taken = branch_outcome(f3_list[i], a, b);
        load_const(5'd1, a);
        load_const(5'd2, b);
        emit(enc_b(13'd12, 5'd2, 5'd1, f3_list[i]));
        emit(enc_i(12'h111, 5'd0, 3'b000, 5'd5, IType_logic));  // fall-through marker
        emit(enc_j(21'd8, 5'd0));
        emit(enc_i(12'h222, 5'd0, 3'b000, 5'd5, IType_logic));  // taken marker
        store_result(5'd5, taken ? 32'h222 : 32'h111);
      end
    end
    run_program();
  endtask

  task automatic test_jumps_upper();
    word_t u1;
    word_t u2;
    word_t p;
    word_t pj;
    word_t pr;
    word_t tgt;
    int fix_idx;
    int j;
    new_program();
    u1 = lcg_next();
    u2 = lcg_next();
    emit(enc_u(u1[31:12], 5'd1, UType_lui));
    store_result(5'd1, {u1[31:12], 12'b0});
    p = here();
    emit(enc_u(u2[31:12], 5'd2, UType_auipc));
    store_result(5'd2, p + {u2[31:12], 12'b0});
    emit(enc_i(12'h123, 5'd0, 3'b000, 5'd5, IType_logic));
    emit(enc_i(12'h0FF, 5'd0, 3'b000, 5'd5, FENCE));   // rd field set, x5 must survive
    store_result(5'd5, 32'h123);
    fix_idx = prog.size();
    emit(NOP);   // becomes the jalr base once the target is known
    j = prog.size();
    pj = here();
    emit(enc_j(21'd12, 5'd3));
    emit(enc_i(12'h555, 5'd0, 3'b000, 5'd7, IType_logic));
    emit(enc_i(12'h555, 5'd0, 3'b000, 5'd7, IType_logic));
    pr = here();
    emit(enc_i(12'd4, 5'd8, 3'b000, 5'd4, IType_jalr));
    emit(enc_i(12'h555, 5'd0, 3'b000, 5'd7, IType_logic));
    tgt = here();
    prog[fix_idx] = enc_i(tgt[11:0] - 12'd3, 5'd0, 3'b000, 5'd8, IType_logic);  // odd sum
    store_result(5'd3, pj + 4);
    store_result(5'd4, pr + 4);
    store_result(5'd7, '0);   // skipped code never ran
    run_program();
    check_pc(pj + 12, pc_log[j + 1]);
    check_pc(tgt, pc_log[j + 2]);
  endtask

  initial begin
    rst_n = 1'b0;
    sentinel_seen = 1'b0;
    test_reset_pc();
    test_alu_reg_imm();
    test_load_store();
    test_branches();
    test_jumps_upper();
    $display("*** PASSED ***");
    $finish;
  end

endmodule

//--- rtl/rv_core.sv
`timescale 1ns/1ps
`include "rv_config.svh"

module rv_core import rv_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  output word_t imem_addr,
  input  word_t imem_rdata,
  output word_t dmem_addr,
  output word_t dmem_wdata,
  output logic  dmem_we,
  input  word_t dmem_rdata
);

  word_t pc;
  word_t pc_next;
  word_t pc_plus4;
  word_t pc_target;     // pc + imm for branches and jal

  word_t rdata1;
  word_t rdata2;
  word_t alu_a;
  word_t alu_b;
  word_t alu_result;
  logic  alu_zero;

  word_t wb_data;
  logic  reg_we;
  logic  has_rd;
  logic  cmp_raw;
  logic  branch_taken;

  decode_if dec ();

  instr_decode u_decode (
    .instr (imem_rdata),
    .dec   (dec.producer)
  );

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc <= `RV_RESET_PC;
    end else begin
      pc <= pc_next;
    end
  end

  assign imem_addr = pc;
  assign pc_plus4  = pc + `RV_ILEN_BYTES;
  assign pc_target = pc + dec.imm_ext;

  // operand A
  always_comb begin
    case (dec.opcode)
      UType_auipc: alu_a = pc;
      UType_lui:   alu_a = '0;
      default:     alu_a = rdata1;
    endcase
  end

  assign alu_b = (dec.opcode == RType || dec.opcode == BType) ? rdata2 : dec.imm_ext;

  alu u_alu (
    .a      (alu_a),
    .b      (alu_b),
    .ctrl   (dec.alu_control),
    .result (alu_result),
    .zero   (alu_zero)
  );

  // beq/bne use zero, the rest the compare bit; funct3[0] flips the sense
  assign cmp_raw      = (dec.funct3[2:1] == 2'b00) ? alu_zero : alu_result[0];
  assign branch_taken = cmp_raw ^ dec.funct3[0];

  always_comb begin
    if (dec.opcode == JType || (dec.opcode == BType && branch_taken)) begin
      pc_next = pc_target;
    end else if (dec.opcode == IType_jalr) begin
      pc_next = {alu_result[`RV_XLEN-1:1], 1'b0};
    end else begin
      pc_next = pc_plus4;
    end
  end

  always_comb begin
    case (dec.opcode)
      IType_load:        wb_data = dmem_rdata;
      JType, IType_jalr: wb_data = pc_plus4;  // link address
      default:           wb_data = alu_result;
    endcase
  end

  always_comb begin
    case (dec.opcode)
      RType, IType_logic, IType_load, IType_jalr,
      JType, UType_lui, UType_auipc: has_rd = 1'b1;
      default:                       has_rd = 1'b0;
    endcase
  end

  assign reg_we = rst_n && has_rd;

  reg_file u_regs (
    .clk    (clk),
    .rst_n  (rst_n),
    .we     (reg_we),
    .waddr  (dec.rd),
    .raddr1 (dec.rs1),
    .raddr2 (dec.rs2),
    .wdata  (wb_data),
    .rdata1 (rdata1),
    .rdata2 (rdata2)
  );

  assign dmem_addr  = alu_result;
  assign dmem_wdata = rdata2;
  assign dmem_we    = rst_n && (dec.opcode == SType);

endmodule

//--- rtl/alu.sv
`timescale 1ns/1ps
`include "rv_config.svh"

module alu import rv_pkg::*; (
  input  word_t     a,
  input  word_t     b,
  input  alu_ctrl_t ctrl,
  output word_t     result,
  output logic      zero
);

  logic [4:0] shamt;

  assign shamt = b[4:0];  // rv32 shifts use 5 bits

  always_comb begin
    case (ctrl)
      ALU_ADD:  result = a + b;
      ALU_SUB:  result = a - b;
      ALU_SLL:  result = a << shamt;
      ALU_SLT:  result = {{(`RV_XLEN-1){1'b0}}, ($signed(a) < $signed(b))};
      ALU_SLTU: result = {{(`RV_XLEN-1){1'b0}}, (a < b)};
      ALU_XOR:  result = a ^ b;
      ALU_SRL:  result = a >> shamt;
      ALU_SRA:  result = word_t'($signed(a) >>> shamt);
      ALU_OR:   result = a | b;
      ALU_AND:  result = a & b;
      default:  result = '0;
    endcase
  end

  // beq/bne look at this after a subtract
  assign zero = (result == '0);

endmodule

//--- rtl/reg_file.sv
`timescale 1ns/1ps
`include "rv_config.svh"

module reg_file import rv_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     we,
  input  reg_idx_t waddr,
  input  reg_idx_t raddr1,
  input  reg_idx_t raddr2,
  input  word_t    wdata,
  output word_t    rdata1,
  output word_t    rdata2
);

  word_t regs [`RV_NREGS];

  // writes to x0 are dropped
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < `RV_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && waddr != '0) begin
      regs[waddr] <= wdata;
    end
  end

  // no bypass, a same-cycle write shows up next cycle
  assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
  assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

//--- rtl/instr_decode.sv
`timescale 1ns/1ps

module instr_decode import rv_pkg::*; (
  input  word_t             instr,
  decode_if.producer        dec
);

  opcode_t    opcode;
  alu_op_t    alu_op;
  logic [2:0] funct3;
  logic [6:0] funct7;     // only nonzero where it selects the alu function

  assign opcode     = opcode_t'(instr[6:0]);
  assign dec.opcode = opcode;
  assign dec.funct3 = funct3;

  // funct3 exists for R, I, S and B formats
  always_comb begin
    funct3 = 3'b000;
    case (opcode)
      RType, IType_logic, IType_load, IType_jalr, SType, BType: begin
        funct3 = instr[14:12];
      end
      default: funct3 = 3'b000;
    endcase
  end

  // immediate shifts carry funct7 in imm[11:5], needed to tell srai from srli
  always_comb begin
    funct7 = 7'b0;
    if (opcode == RType) begin
      funct7 = instr[31:25];
    end else if (opcode == IType_logic && funct3 == 3'b101) begin
      funct7 = instr[31:25];
    end
  end

  // op class per opcode
  always_comb begin
    case (opcode)
      RType:       alu_op = ALU_OP__REGISTER_OPERATION;
      IType_logic: alu_op = ALU_OP__REGISTER_OPERATION; // funct3 picks the function
      IType_load:  alu_op = ALU_OP__ADD;                 // rs1 + offset
      IType_jalr:  alu_op = ALU_OP__ADD;
      SType:       alu_op = ALU_OP__ADD;
      BType:       alu_op = ALU_OP__BRANCH;
      UType_auipc: alu_op = ALU_OP__ADD;                 // pc + upper imm
      UType_lui:   alu_op = ALU_OP__ADD;                 // 0 + upper imm
      FENCE:       alu_op = ALU_OP__UNSET;
      default:     alu_op = ALU_OP__UNSET;
    endcase
  end

  // register indices, unused ones forced to x0
  always_comb begin
    dec.rd  = '0;
    dec.rs1 = '0;
    dec.rs2 = '0;
    case (opcode)
      RType: begin
        dec.rd  = instr[11:7];
        dec.rs1 = instr[19:15];
        dec.rs2 = instr[24:20];
      end
      IType_logic, IType_load, IType_jalr: begin
        dec.rd  = instr[11:7];
        dec.rs1 = instr[19:15];
      end
      SType, BType: begin
        dec.rs1 = instr[19:15];
        dec.rs2 = instr[24:20];
      end
      JType, UType_lui, UType_auipc: begin
        dec.rd = instr[11:7];
      end
      default: begin
        dec.rd  = '0;
        dec.rs1 = '0;
        dec.rs2 = '0;
      end
    endcase
  end

  // immediate generation
  always_comb begin
    case (opcode)
      IType_logic, IType_load, IType_jalr: begin
        dec.imm_ext = {{20{instr[31]}}, instr[31:20]};
      end
      SType: begin
        dec.imm_ext = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      end
      BType: begin
        dec.imm_ext = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
      end
      JType: begin
        dec.imm_ext = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
      end
      UType_lui, UType_auipc: begin
        dec.imm_ext = {instr[31:12], 12'b0};
      end
      default: dec.imm_ext = '0;
    endcase
  end

  alu_decoder u_alu_dec (
    .alu_op      (alu_op),
    .funct3      (funct3),
    .funct7      (funct7),
    .alu_control (dec.alu_control)
  );

endmodule

//--- rtl/alu_decoder.sv
`timescale 1ns/1ps

module alu_decoder import rv_pkg::*; (
  input  alu_op_t    alu_op,
  input  logic [2:0] funct3,
  input  logic [6:0] funct7,
  output alu_ctrl_t  alu_control
);

  logic r_type;   // funct7 only reaches us for R-type and immediate shifts

  assign r_type = |funct7;

  always_comb begin
    alu_control = ALU_ADD;
    case (alu_op)
      ALU_OP__ADD: alu_control = ALU_ADD;

      // compare via the alu, the core reads zero or result[0]
      ALU_OP__BRANCH: begin
        case (funct3)
          F3_BEQ, F3_BNE:   alu_control = ALU_SUB;
          F3_BLT, F3_BGE:   alu_control = ALU_SLT;
          F3_BLTU, F3_BGEU: alu_control = ALU_SLTU;
          default:          alu_control = ALU_SUB;
        endcase
      end

      ALU_OP__REGISTER_OPERATION: begin
        case (funct3)
          3'b000:  alu_control = (r_type && funct7[5]) ? ALU_SUB : ALU_ADD;
          3'b001:  alu_control = ALU_SLL;
          3'b010:  alu_control = ALU_SLT;
          3'b011:  alu_control = ALU_SLTU;
          3'b100:  alu_control = ALU_XOR;
          3'b101:  alu_control = funct7[5] ? ALU_SRA : ALU_SRL;
          3'b110:  alu_control = ALU_OR;
          3'b111:  alu_control = ALU_AND;
          default: alu_control = ALU_ADD;
        endcase
      end

      ALU_OP__UNSET: alu_control = ALU_ADD;
      default:       alu_control = ALU_ADD;
    endcase
  end

endmodule

//--- rtl/decode_if.sv
`timescale 1ns/1ps

// decoded instruction fields, valid whenever the fetched word is stable
interface decode_if import rv_pkg::*; ();

  opcode_t   opcode;
  alu_ctrl_t alu_control;
  word_t     imm_ext;    // sign-extended per format
  logic [2:0] funct3;
  reg_idx_t  rd;
  reg_idx_t  rs1;
  reg_idx_t  rs2;

  modport producer (
    output opcode,
    output alu_control,
    output imm_ext,
    output funct3,
    output rd,
    output rs1,
    output rs2
  );

  modport consumer (
    input opcode,
    input alu_control,
    input imm_ext,
    input funct3,
    input rd,
    input rs1,
    input rs2
  );

endinterface

//--- rtl/rv_pkg.sv
`include "rv_config.svh"

package rv_pkg;

  // data, address and immediate words all share one width
  typedef logic [`RV_XLEN-1:0] word_t;

  typedef logic [$clog2(`RV_NREGS)-1:0] reg_idx_t;

  // major opcodes, instr[6:0]
  typedef enum logic [6:0] {
    RType       = 7'b0110011,
    IType_logic = 7'b0010011,
    IType_load  = 7'b0000011,
    IType_jalr  = 7'b1100111,
    SType       = 7'b0100011,
    BType       = 7'b1100011,
    JType       = 7'b1101111,
    UType_lui   = 7'b0110111,
    UType_auipc = 7'b0010111,
    FENCE       = 7'b0001111
  } opcode_t;

  // op class handed from the main decoder to the alu decoder
  typedef enum logic [1:0] {
    ALU_OP__ADD                = 2'b00,
    ALU_OP__BRANCH             = 2'b01,
    ALU_OP__REGISTER_OPERATION = 2'b10,
    ALU_OP__UNSET              = 2'b11
  } alu_op_t;

  // alu function select
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_SLL  = 4'd2,
    ALU_SLT  = 4'd3,
    ALU_SLTU = 4'd4,
    ALU_XOR  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_OR   = 4'd8,
    ALU_AND  = 4'd9
  } alu_ctrl_t;

  // funct3 encodings of the branch group, used by the alu decoder
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

endpackage

//--- rtl/rv_config.svh
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// datapath width in bits
`define RV_XLEN 32

// architectural registers, x0 included
`define RV_NREGS 32

// first fetch address after reset
`define RV_RESET_PC 32'h0000_0000

// pc step for a 32-bit instruction
`define RV_ILEN_BYTES 4

`endif
